//--- cp0RegPkg.sv
package cp0RegPkg;

    typedef logic [4:0] cp0Addr;
    typedef logic [2:0] cp0Sel;

    localparam cp0Addr regBadVAddr  = 5'd8;
    localparam cp0Addr regCount     = 5'd9;
    localparam cp0Addr regCompare   = 5'd11;
    localparam cp0Addr regStatus    = 5'd12;
    localparam cp0Addr regCause     = 5'd13;
    localparam cp0Addr regEpc       = 5'd14;
    localparam cp0Addr regPrIdEBase = 5'd15; // PRId on sel 0, EBase on sel 1
    localparam cp0Addr regConfig    = 5'd16;

    localparam cp0Sel selPrId   = 3'd0;
    localparam cp0Sel selEBase  = 3'd1;
    localparam cp0Sel selConfig = 3'd0;

    localparam logic [31:0] statusWriteMask  = 32'h0040_FF07; // IM, BEV, ERL, EXL, IE
    localparam logic [31:0] causeWriteMask   = 32'h00C0_0300; // IV, WP, software IP
    localparam logic [31:0] epcWriteMask     = 32'hFFFF_FFFF;
    localparam logic [31:0] ebaseWriteMask   = 32'h3FFF_F000; // Exception base only
    localparam logic [31:0] compareWriteMask = 32'hFFFF_FFFF;
    localparam logic [31:0] countWriteMask   = 32'hFFFF_FFFF;

    localparam logic [31:0] statusResetValue = 32'h1040_0004; // CU0, BEV, ERL
    localparam logic [31:0] prIdValue        = 32'h00FF_0000;
    localparam logic [31:0] ebaseResetValue  = 32'h8000_0000;
    localparam logic [31:0] configResetValue = 32'h8000_0080;

    localparam int statusIe   = 0;
    localparam int statusExl  = 1;
    localparam int statusErl  = 2;
    localparam int statusImLo = 8;
    localparam int statusImHi = 15;
    localparam int statusBev  = 22;

    localparam int causeExcLo = 2;
    localparam int causeExcHi = 6;
    localparam int causeIpLo  = 8;
    localparam int causeIpHi  = 15; // IP7 shares the timer
    localparam int causeTi    = 30;
    localparam int causeBd    = 31;

endpackage

//--- excPkg.sv
package excPkg;

    typedef enum logic [3:0] {
        ExcNone,
        ExcInterrupt,
        ExcAddressErrIF,
        ExcAddressErrL,
        ExcAddressErrS,
        ExcReservedInst,
        ExcSysCall,
        ExcBreak,
        ExcIntOverflow,
        ExcEret
    } excType;

    typedef enum logic [4:0] {
        ExcCodeInt  = 5'd0,
        ExcCodeAdEL = 5'd4,
        ExcCodeAdES = 5'd5,
        ExcCodeSys  = 5'd8,
        ExcCodeBp   = 5'd9,
        ExcCodeRI   = 5'd10,
        ExcCodeOv   = 5'd12
    } excCode;

    localparam logic [31:0] bootVector    = 32'hBFC0_0380;
    localparam logic [31:0] generalOffset = 32'h0000_0180;

    function automatic excCode excCodeOf(input excType kind);
        case (kind)
            ExcAddressErrIF, ExcAddressErrL: return ExcCodeAdEL; // Fetch faults report as load
            ExcAddressErrS:  return ExcCodeAdES;
            ExcReservedInst: return ExcCodeRI;
            ExcSysCall:      return ExcCodeSys;
            ExcBreak:        return ExcCodeBp;
            ExcIntOverflow:  return ExcCodeOv;
            default:         return ExcCodeInt;
        endcase
    endfunction

endpackage

//--- cp0Interfaces.sv
interface faultIf ();
    logic        fetchAddrErr;
    logic        reservedInst;
    logic        sysCall;
    logic        breakInst;
    logic        overflow;
    logic        loadAddrErr;
    logic        storeAddrErr;
    logic        eret;    // Not a fault, ranked below all of them
    logic [31:0] badAddr;

    modport source (output fetchAddrErr, reservedInst, sysCall, breakInst, overflow,
                    loadAddrErr, storeAddrErr, eret, badAddr);
    modport sink (input fetchAddrErr, reservedInst, sysCall, breakInst, overflow,
                  loadAddrErr, storeAddrErr, eret, badAddr);
endinterface

interface excCommitIf import excPkg::*; ();
    logic        valid;  // One cycle, recorded on that edge
    excType      kind;
    logic [31:0] pc;
    logic        isDelaySlot;
    logic [31:0] badAddr;

    modport driver (output valid, kind, pc, isDelaySlot, badAddr);
    modport receiver (input valid, kind, pc, isDelaySlot, badAddr);
endinterface

interface cp0StateIf ();
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] ebase;
    logic        timerInt;

    modport driver (output status, cause, epc, ebase, timerInt);
    modport reader (input status, cause, epc, ebase, timerInt);
endinterface

//--- cp0RegFile.sv
module cp0RegFile import cp0RegPkg::*, excPkg::*; #(
    parameter int countHalfRate = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEn,
    input  cp0Addr      addr,
    input  cp0Sel       sel,
    input  logic [31:0] writeData,
    output logic [31:0] readData,
    input  logic [5:0]  hwIp,
    excCommitIf.receiver commit,
    cp0StateIf.driver    state
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] ebase;
    logic        halfTick;
    logic        countStep;
    logic        timerHit;
    logic        isAddrErr;

    function automatic logic [31:0] maskedWrite(input logic [31:0] oldVal,
                                                input logic [31:0] newVal,
                                                input logic [31:0] mask);
        return (oldVal & ~mask) | (newVal & mask);
    endfunction

    assign countStep = (countHalfRate != 0) ? halfTick : 1'b1;
    assign timerHit  = (count == compare);
    assign isAddrErr = (commit.kind == ExcAddressErrIF) || (commit.kind == ExcAddressErrL) ||
                       (commit.kind == ExcAddressErrS);

    always_ff @(posedge clk) begin
        if (rst) begin
            status   <= statusResetValue;
            cause    <= '0;
            count    <= '0;
            compare  <= '0;
            ebase    <= ebaseResetValue;
            halfTick <= 1'b0;
        end else begin
            halfTick <= ~halfTick;
            if (countStep) begin
                count <= count + 32'd1;
            end
            cause[causeTi]                     <= timerHit;
            cause[causeIpHi]                   <= hwIp[5] | timerHit;
            cause[causeIpHi-1:causeIpLo+2]     <= hwIp[4:0]; // IP6..IP2

            if (commit.valid) begin // Exception beats a same-cycle mtc0
                if (commit.kind == ExcEret) begin
                    status[statusExl] <= 1'b0;
                end else if (!status[statusExl]) begin
                    status[statusExl]            <= 1'b1;
                    cause[causeBd]               <= commit.isDelaySlot;
                    cause[causeExcHi:causeExcLo] <= excCodeOf(commit.kind);
                    epc <= commit.isDelaySlot ? commit.pc - 32'd4 : commit.pc;
                    if (isAddrErr) begin
                        badVAddr <= commit.badAddr;
                    end
                end
            end else if (writeEn) begin
                case (addr)
                    regCount:   count   <= maskedWrite(count, writeData, countWriteMask);
                    regCompare: compare <= maskedWrite(compare, writeData, compareWriteMask);
                    regStatus:  status  <= maskedWrite(status, writeData, statusWriteMask);
                    regEpc:     epc     <= maskedWrite(epc, writeData, epcWriteMask);
                    regCause: begin
                        for (int i = 0; i < 32; i++) begin
                            if (causeWriteMask[i]) begin
                                cause[i] <= writeData[i]; // Hardware IP bits untouched
                            end
                        end
                    end
                    regPrIdEBase: begin
                        if (sel == selEBase) begin
                            ebase <= maskedWrite(ebase, writeData, ebaseWriteMask);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr)
            regBadVAddr: readData = badVAddr;
            regCount:    readData = count;
            regCompare:  readData = compare;
            regStatus:   readData = status;
            regCause:    readData = cause;
            regEpc:      readData = epc;
            regPrIdEBase: begin
                case (sel)
                    selPrId:  readData = prIdValue;
                    selEBase: readData = ebase;
                    default:  readData = '0;
                endcase
            end
            regConfig:   readData = (sel == selConfig) ? configResetValue : '0;
            default:     readData = '0;
        endcase
    end

    assign state.status   = status;
    assign state.cause    = cause;
    assign state.epc      = epc;
    assign state.ebase    = ebase;
    assign state.timerInt = cause[causeTi];

endmodule

//--- interruptCollector.sv
module interruptCollector import cp0RegPkg::*; #(
    parameter int syncStages = 2 // 2 or 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] irq,
    cp0StateIf.reader  state,
    output logic [5:0] hwIp,
    output logic       intPending
);

    logic [syncStages-1:0][5:0] syncChain;
    logic [7:0]                 ipBits;
    logic [7:0]                 imBits;
    logic                       intEnabled;

    always_ff @(posedge clk) begin
        if (rst) begin
            syncChain <= '0;
        end else begin
            syncChain <= {syncChain[syncStages-2:0], irq}; // Oldest sample on top
        end
    end

    assign hwIp = syncChain[syncStages-1];

    // Timer also lands on IP7
    assign ipBits = state.cause[causeIpHi:causeIpLo] | {state.timerInt, 7'b0};
    assign imBits = state.status[statusImHi:statusImLo];

    assign intEnabled = state.status[statusIe] && !state.status[statusExl] &&
                        !state.status[statusErl];

    assign intPending = intEnabled && ((ipBits & imBits) != 8'b0);

endmodule

//--- faultPrioritizer.sv
module faultPrioritizer import excPkg::*; (
    faultIf.sink        faults,
    output excType      faultKind,
    output logic [31:0] faultAddr
);

    always_comb begin
        if (faults.fetchAddrErr) begin
            faultKind = ExcAddressErrIF; // Fetch fault masks everything after it
        end else if (faults.reservedInst) begin
            faultKind = ExcReservedInst;
        end else if (faults.sysCall) begin
            faultKind = ExcSysCall;
        end else if (faults.breakInst) begin
            faultKind = ExcBreak;
        end else if (faults.overflow) begin
            faultKind = ExcIntOverflow;
        end else if (faults.loadAddrErr) begin
            faultKind = ExcAddressErrL;
        end else if (faults.storeAddrErr) begin
            faultKind = ExcAddressErrS;
        end else if (faults.eret) begin
            faultKind = ExcEret;
        end else begin
            faultKind = ExcNone;
        end
    end

    always_comb begin
        case (faultKind)
            ExcAddressErrIF, ExcAddressErrL, ExcAddressErrS: faultAddr = faults.badAddr;
            default: faultAddr = '0;
        endcase
    end

endmodule

//--- trapController.sv
module trapController import cp0RegPkg::*, excPkg::*; (
    input  logic        commitValid,
    input  logic [31:0] commitPc,
    input  logic        commitIsDelaySlot,
    input  logic        intPending,
    input  excType      faultKind,
    input  logic [31:0] faultAddr,
    cp0StateIf.reader   state,
    excCommitIf.driver  commit,
    output logic        trapTaken,
    output logic [31:0] trapTarget
);

    excType chosenKind;

    always_comb begin
        chosenKind = ExcNone;
        if (commitValid) begin
            chosenKind = intPending ? ExcInterrupt : faultKind; // Interrupt outranks faults
        end
    end

    assign trapTaken = (chosenKind != ExcNone);

    always_comb begin
        if (chosenKind == ExcEret) begin
            trapTarget = state.epc;
        end else if (state.status[statusBev]) begin
            trapTarget = bootVector;
        end else begin
            trapTarget = {state.ebase[31:12], 12'h000} + generalOffset;
        end
    end

    assign commit.valid       = trapTaken;
    assign commit.kind        = chosenKind;
    assign commit.pc          = commitPc;
    assign commit.isDelaySlot = commitIsDelaySlot;
    assign commit.badAddr     = faultAddr;

endmodule

//--- cp0Subsystem.sv
module cp0Subsystem import cp0RegPkg::*, excPkg::*; #(
    parameter int countHalfRate = 1,
    parameter int syncStages    = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEn,
    input  cp0Addr      addr,
    input  cp0Sel       sel,
    input  logic [31:0] writeData,
    output logic [31:0] readData,
    input  logic [5:0]  irq,
    input  logic        commitValid,
    input  logic [31:0] commitPc,
    input  logic        commitIsDelaySlot,
    input  logic        fetchAddrErr,
    input  logic        reservedInst,
    input  logic        sysCall,
    input  logic        breakInst,
    input  logic        overflow,
    input  logic        loadAddrErr,
    input  logic        storeAddrErr,
    input  logic        eret,
    input  logic [31:0] badAddr,
    output logic        trapTaken,
    output logic [31:0] trapTarget,
    output logic        intPending
);

    logic [5:0]  hwIp;
    excType      faultKind;
    logic [31:0] faultAddr;

    faultIf     faults ();
    excCommitIf commitBus ();
    cp0StateIf  stateBus ();

    assign faults.fetchAddrErr = fetchAddrErr;
    assign faults.reservedInst = reservedInst;
    assign faults.sysCall      = sysCall;
    assign faults.breakInst    = breakInst;
    assign faults.overflow     = overflow;
    assign faults.loadAddrErr  = loadAddrErr;
    assign faults.storeAddrErr = storeAddrErr;
    assign faults.eret         = eret;
    assign faults.badAddr      = badAddr;

    cp0RegFile #(
        .countHalfRate(countHalfRate)
    ) regFile (
        .clk(clk),
        .rst(rst),
        .writeEn(writeEn),
        .addr(addr),
        .sel(sel),
        .writeData(writeData),
        .readData(readData),
        .hwIp(hwIp),
        .commit(commitBus.receiver),
        .state(stateBus.driver)
    );

    interruptCollector #(
        .syncStages(syncStages)
    ) intCollector (
        .clk(clk),
        .rst(rst),
        .irq(irq),
        .state(stateBus.reader),
        .hwIp(hwIp),
        .intPending(intPending)
    );

    faultPrioritizer prioritizer (
        .faults(faults.sink),
        .faultKind(faultKind),
        .faultAddr(faultAddr)
    );

    trapController trapCtrl (
        .commitValid(commitValid),
        .commitPc(commitPc),
        .commitIsDelaySlot(commitIsDelaySlot),
        .intPending(intPending),
        .faultKind(faultKind),
        .faultAddr(faultAddr),
        .state(stateBus.reader),
        .commit(commitBus.driver),
        .trapTaken(trapTaken),
        .trapTarget(trapTarget)
    );

endmodule

//--- cp0Subsystem_assertions.sv
module cp0SubsystemAssertions import cp0RegPkg::*, excPkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        commitValid,
    input logic        trapTaken,
    input logic [31:0] trapTarget,
    input excType      kind,
    input logic [31:0] status,
    input logic [31:0] epc
);

    trapNeedsCommit: assert property (@(posedge clk) disable iff (rst)
        trapTaken |-> commitValid)
        else $error("trapTaken raised without commitValid");

    // First-level exception must enter EXL on the next cycle
    trapSetsExl: assert property (@(posedge clk) disable iff (rst)
        (trapTaken && kind != ExcEret && !status[statusExl]) |=> status[statusExl])
        else $error("EXL not set after a trap");

    eretToEpc: assert property (@(posedge clk) disable iff (rst)
        (trapTaken && kind == ExcEret) |-> (trapTarget == epc))
        else $error("eret target differs from EPC");

endmodule

bind cp0Subsystem cp0SubsystemAssertions checks (
    .clk(clk),
    .rst(rst),
    .commitValid(commitValid),
    .trapTaken(trapTaken),
    .trapTarget(trapTarget),
    .kind(commitBus.kind),
    .status(stateBus.status),
    .epc(stateBus.epc)
);

//--- cp0Tb.sv
module cp0Tb import cp0RegPkg::*;;

    localparam int timeoutCycles = 2000; // Whole run needs about 200 cycles

    localparam logic [6:0] flagSys = 7'b0010000; // {fetch, ri, sys, bp, ov, ld, st}
    localparam logic [6:0] flagBp  = 7'b0001000;

    logic        clk;
    logic        rst;
    logic        writeEn;
    cp0Addr      addr;
    cp0Sel       sel;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic [5:0]  irq;
    logic        commitValid;
    logic [31:0] commitPc;
    logic        commitIsDelaySlot;
    logic        fetchAddrErr, reservedInst, sysCall, breakInst;
    logic        overflow, loadAddrErr, storeAddrErr, eret;
    logic [31:0] badAddr;
    logic        trapTaken;
    logic [31:0] trapTarget;
    logic        intPending;
    logic [31:0] ebaseExp;
    logic [31:0] generalTarget;
    integer      seed;
    int          cycleCount = 0;

    cp0Subsystem dut_i (
        .clk(clk),
        .rst(rst),
        .writeEn(writeEn),
        .addr(addr),
        .sel(sel),
        .writeData(writeData),
        .readData(readData),
        .irq(irq),
        .commitValid(commitValid),
        .commitPc(commitPc),
        .commitIsDelaySlot(commitIsDelaySlot),
        .fetchAddrErr(fetchAddrErr),
        .reservedInst(reservedInst),
        .sysCall(sysCall),
        .breakInst(breakInst),
        .overflow(overflow),
        .loadAddrErr(loadAddrErr),
        .storeAddrErr(storeAddrErr),
        .eret(eret),
        .badAddr(badAddr),
        .trapTaken(trapTaken),
        .trapTarget(trapTarget),
        .intPending(intPending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] codeField(input logic [31:0] causeVal);
        return 32'(causeVal[causeExcHi:causeExcLo]);
    endfunction

    task automatic writeReg(input cp0Addr a, input cp0Sel s, input logic [31:0] d);
        @(posedge clk);
        writeEn   <= 1'b1;
        addr      <= a;
        sel       <= s;
        writeData <= d;
        @(posedge clk);
        writeEn <= 1'b0; // Write lands on this edge
    endtask

    task automatic readReg(input cp0Addr a, input cp0Sel s, output logic [31:0] d);
        @(posedge clk);
        addr <= a;
        sel  <= s;
        @(negedge clk);
        d = readData;
    endtask

    task automatic expectReg(input string name, input cp0Addr a, input cp0Sel s,
                             input logic [31:0] expected);
        logic [31:0] value;
        readReg(a, s, value);
        checkEq(name, expected, value);
    endtask

    task automatic commitInst(input string name, input logic [6:0] flags, input logic isEret,
                              input logic [31:0] pc, input logic inSlot,
                              input logic [31:0] addrBad, input logic [31:0] expTarget);
        @(posedge clk);
        commitValid       <= 1'b1;
        commitPc          <= pc;
        commitIsDelaySlot <= inSlot;
        badAddr           <= addrBad;
        eret              <= isEret;
        {fetchAddrErr, reservedInst, sysCall, breakInst, overflow, loadAddrErr,
         storeAddrErr} <= flags;
        @(negedge clk);
        checkEq({name, " taken"}, 32'd1, 32'(trapTaken));
        checkEq({name, " target"}, expTarget, trapTarget);
        @(posedge clk); // Exception recorded here
        commitValid <= 1'b0;
        eret        <= 1'b0;
        {fetchAddrErr, reservedInst, sysCall, breakInst, overflow, loadAddrErr,
         storeAddrErr} <= '0;
    endtask

    task automatic waitPending(input string name, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!intPending && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        checkEq(name, 32'd1, 32'(intPending));
    endtask

    task automatic testResetValues();
        expectReg("reset Status", regStatus, 3'd0, 32'h1040_0004);
        expectReg("reset PRId", regPrIdEBase, selPrId, 32'h00FF_0000);
        expectReg("reset EBase", regPrIdEBase, selEBase, 32'h8000_0000);
        expectReg("reset Config", regConfig, 3'd0, 32'h8000_0080);
        expectReg("reset Cause", regCause, 3'd0, 32'h0); // Timer hit at Count 0 has passed
    endtask

    task automatic testMaskedWrites();
        logic [31:0] value;
        value = $random(seed);
        writeReg(regStatus, 3'd0, value);
        expectReg("Status write", regStatus, 3'd0,
                  (32'h1040_0004 & ~statusWriteMask) | (value & statusWriteMask));
        value = $random(seed);
        writeReg(regCause, 3'd0, value);
        expectReg("Cause write", regCause, 3'd0, value & causeWriteMask);
        value = $random(seed);
        writeReg(regEpc, 3'd0, value);
        expectReg("EPC write", regEpc, 3'd0, value & epcWriteMask);
        value = $random(seed);
        writeReg(regPrIdEBase, selEBase, value);
        ebaseExp = (32'h8000_0000 & ~ebaseWriteMask) | (value & ebaseWriteMask);
        generalTarget = {ebaseExp[31:12], 12'h000} + 32'h180;
        expectReg("EBase write", regPrIdEBase, selEBase, ebaseExp);
        value = $random(seed);
        writeReg(regCompare, 3'd0, value);
        expectReg("Compare write", regCompare, 3'd0, value & compareWriteMask);
        writeReg(regPrIdEBase, selPrId, $random(seed));
        expectReg("PRId write", regPrIdEBase, selPrId, 32'h00FF_0000);
    endtask

    task automatic testSysCall();
        logic [31:0] value;
        writeReg(regStatus, 3'd0, 32'h0040_0000); // BEV only
        commitInst("syscall", flagSys, 1'b0, 32'h0040_1000, 1'b0, 32'h0, 32'hBFC0_0380);
        readReg(regCause, 3'd0, value);
        checkEq("syscall code", 32'd8, codeField(value));
        checkEq("syscall BD", 32'd0, 32'(value[causeBd]));
        expectReg("syscall EPC", regEpc, 3'd0, 32'h0040_1000);
        commitInst("nested break", flagBp, 1'b0, 32'h0040_2000, 1'b0, 32'h0, 32'hBFC0_0380);
        expectReg("nested EPC", regEpc, 3'd0, 32'h0040_1000);
        writeReg(regStatus, 3'd0, 32'h0);
        commitInst("slot syscall", flagSys, 1'b0, 32'h0040_3004, 1'b1, 32'h0, generalTarget);
        readReg(regCause, 3'd0, value);
        checkEq("slot syscall code", 32'd8, codeField(value));
        checkEq("slot syscall BD", 32'd1, 32'(value[causeBd]));
        expectReg("slot syscall EPC", regEpc, 3'd0, 32'h0040_3000);
    endtask

    task automatic checkPriority(input string name, input logic [6:0] flags,
                                 input logic [31:0] expCode, input logic checkBad);
        logic [31:0] errAddr;
        logic [31:0] value;
        errAddr = $random(seed);
        writeReg(regStatus, 3'd0, 32'h0); // Leave exception level
        commitInst(name, flags, 1'b0, 32'h0040_4000, 1'b0, errAddr, generalTarget);
        readReg(regCause, 3'd0, value);
        checkEq({name, " code"}, expCode, codeField(value));
        if (checkBad) begin
            expectReg({name, " BadVAddr"}, regBadVAddr, 3'd0, errAddr);
        end
    endtask

    task automatic testPriority();
        checkPriority("all faults", 7'b1111111, 32'd4, 1'b0);
        checkPriority("reserved inst", 7'b0111111, 32'd10, 1'b0);
        checkPriority("syscall over break", 7'b0011111, 32'd8, 1'b0);
        checkPriority("break over overflow", 7'b0001111, 32'd9, 1'b0);
        checkPriority("overflow over load", 7'b0000111, 32'd12, 1'b0);
        checkPriority("load over store", 7'b0000011, 32'd4, 1'b1);
        checkPriority("store only", 7'b0000001, 32'd5, 1'b1);
    endtask

    task automatic testEret();
        logic [31:0] value;
        writeReg(regEpc, 3'd0, 32'h0040_5ABC);
        commitInst("eret", 7'b0, 1'b1, 32'h0040_6000, 1'b0, 32'h0, 32'h0040_5ABC);
        readReg(regStatus, 3'd0, value);
        checkEq("eret EXL", 32'd0, 32'(value[statusExl]));
    endtask

    task automatic testInterrupts();
        logic [31:0] value;
        logic [31:0] countNow;
        int          waited;
        writeReg(regStatus, 3'd0, 32'h0040_0101); // BEV, IM0, IE
        writeReg(regCause, 3'd0, 32'h0000_0100);
        waitPending("software pending", 4);
        commitInst("interrupt", 7'b0, 1'b0, 32'h0040_7000, 1'b0, 32'h0, 32'hBFC0_0380);
        readReg(regCause, 3'd0, value);
        checkEq("interrupt code", 32'd0, codeField(value));
        writeReg(regCause, 3'd0, 32'h0);
        writeReg(regStatus, 3'd0, 32'h0040_0401); // IM2 for irq line 0
        @(posedge clk);
        irq <= 6'b000001;
        waitPending("hardware pending", 3);
        @(posedge clk);
        irq <= 6'b0;
        writeReg(regStatus, 3'd0, 32'h0040_0000);
        readReg(regCount, 3'd0, countNow);
        writeReg(regCompare, 3'd0, countNow + 32'd6);
        waited = 0;
        readReg(regCause, 3'd0, value);
        while (!value[causeTi] && waited < 40) begin
            readReg(regCause, 3'd0, value);
            waited++;
        end
        checkEq("timer TI", 32'd1, 32'(value[causeTi]));
    endtask

    initial begin
        seed              = 32'h586d_212e;
        rst               = 1'b1;
        writeEn           = 1'b0;
        addr              = '0;
        sel               = '0;
        writeData         = '0;
        irq               = '0;
        commitValid       = 1'b0;
        commitPc          = '0;
        commitIsDelaySlot = 1'b0;
        {fetchAddrErr, reservedInst, sysCall, breakInst} = '0;
        {overflow, loadAddrErr, storeAddrErr, eret}      = '0;
        badAddr           = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        testResetValues();
        testMaskedWrites();
        testSysCall();
        testPriority();
        testEret();
        testInterrupts();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- filelist.f
cp0RegPkg.sv
excPkg.sv
cp0Interfaces.sv
cp0RegFile.sv
interruptCollector.sv
faultPrioritizer.sv
trapController.sv
cp0Subsystem.sv
cp0Subsystem_assertions.sv
cp0Tb.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/Vcp0Tb
	./obj_dir/Vcp0Tb > sim.log 2>&1; cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

obj_dir/Vcp0Tb: filelist.f $(SRCS)
	verilator --binary --assert --top-module cp0Tb -f filelist.f

clean:
	rm -rf obj_dir sim.log
